// ==== files.f ====
design/cu_pkg.sv
design/instr_decoder.sv
design/state_sequencer.sv
design/control_encoder.sv
design/control_unit.sv
verif/control_unit_checker.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cu_pkg::*; ();

	localparam int unsigned fetch_wait_cycles = 2;
	localparam int unsigned instr_count = 400;
	localparam funct_t kept_functs [12] = '{
		6'h20, 6'h24, 6'h22, 6'h00, 6'h02, 6'h03,
		6'h04, 6'h07, 6'h10, 6'h12, 6'h2a, 6'h05
	};

	logic    clock;
	logic    reset;
	opcode_t opcode;
	funct_t  funct;
	ctrl_t   ctrl;
	state_t  state;

	instr_class_t model_class;   // class the model expects in the decode latch
	shift_op_t    model_shift;
	int           cycle_count;   // cycles since entering fetch

	control_unit #(
		.fetch_wait_cycles (fetch_wait_cycles)
	) dut_i (
		.clock  (clock),
		.reset  (reset),
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrl),
		.state  (state)
	);

	bind control_unit control_unit_checker checker_i (
		.clock (clock),
		.reset (reset),
		.ctrl  (ctrl),
		.state (state)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// half legal r-type, half anything
	initial begin
		void'($urandom(32'hf3be13eb));
		opcode = '0;
		funct  = '0;
		forever begin
			@(posedge clock);
			if ($urandom_range(1, 0) == 0) begin
				opcode <= '0;
				funct  <= kept_functs[4'($urandom_range(11, 0))];
			end else begin
				opcode <= opcode_t'($urandom);
				funct  <= funct_t'($urandom);
			end
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			abort_run($sformatf("** Error at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	// control word per state, from the encoder table
	function automatic ctrl_t expected_ctrl(state_t st, instr_class_t cls, shift_op_t sk);
		ctrl_t c;
		c = '0;   // every default encodes as zero
		case (st)
			st_reset: begin
				c.reg_write  = 1'b1;
				c.reg_dst    = dst_sp;
				c.mem_to_reg = wb_sp_init;
			end
			st_fetch, st_fetch2: begin
				c.ir_write  = (st == st_fetch);
				c.pc_write  = (st == st_fetch2);
				c.alu_src_b = src_b_four;
				c.alu_op    = alu_add;
			end
			st_decode: begin
				c.alu_src_b     = src_b_offset;
				c.alu_op        = alu_add;
				c.alu_out_write = 1'b1;
				c.a_write       = 1'b1;
				c.b_write       = 1'b1;
				c.xch_write     = 1'b1;
			end
			st_add, st_and, st_sub: begin
				c.alu_src_a     = src_a_reg;
				c.alu_out_write = 1'b1;
				c.alu_op = (st == st_add) ? alu_add : (st == st_and) ? alu_and : alu_sub;
			end
			st_write_arith, st_mfhi, st_mflo, st_shift_write: begin
				c.reg_write  = 1'b1;
				c.reg_dst    = dst_rd;
				c.mem_to_reg = (st == st_mfhi) ? wb_hi : (st == st_mflo) ? wb_lo :
					(st == st_shift_write) ? wb_shift : wb_alu_out;
			end
			st_slt: begin
				c.reg_write  = 1'b1;
				c.reg_dst    = dst_rd;
				c.mem_to_reg = wb_less;
				c.alu_src_a  = src_a_reg;
				c.alu_op     = alu_compare;
			end
			st_xch1, st_xch2: begin
				c.reg_write  = 1'b1;
				c.reg_dst    = (st == st_xch1) ? dst_rs : dst_rt;
				c.mem_to_reg = (st == st_xch1) ? wb_rt : wb_xch;
			end
			st_shiftv_load: begin
				c.shift_src = 1'b1;
				c.shamt_src = 1'b1;
			end
			st_shift_exec: begin
				c.shift_src = (cls == cls_shift_var);
				c.shamt_src = (cls == cls_shift_var);
				c.shift_op  = sk;
			end
			default: ;   // shift load and final use defaults
		endcase
		return c;
	endfunction

	function automatic instr_class_t classify(opcode_t op, funct_t fn);
		if (op != 6'h00) begin
			return cls_unknown;
		end
		case (fn)
			6'h20: return cls_add;
			6'h24: return cls_and;
			6'h22: return cls_sub;
			6'h00, 6'h02, 6'h03: return cls_shift_imm;
			6'h04, 6'h07: return cls_shift_var;
			6'h10: return cls_mfhi;
			6'h12: return cls_mflo;
			6'h2a: return cls_slt;
			6'h05: return cls_xch;
			default: return cls_unknown;
		endcase
	endfunction

	function automatic shift_op_t shift_kind(funct_t fn);
		case (fn)
			6'h00, 6'h04: return shift_left;
			6'h02: return shift_right_logical;
			6'h03, 6'h07: return shift_right_arith;
			default: return shift_load;
		endcase
	endfunction

	// path of each class from decode up to final
	function automatic state_t successor(state_t st, instr_class_t cls);
		case (st)
			st_decode: begin
				case (cls)
					cls_add: return st_add;
					cls_and: return st_and;
					cls_sub: return st_sub;
					cls_shift_imm: return st_shift_load;
					cls_shift_var: return st_shiftv_load;
					cls_mfhi: return st_mfhi;
					cls_mflo: return st_mflo;
					cls_slt: return st_slt;
					cls_xch: return st_xch1;
					default: return st_final;
				endcase
			end
			st_add, st_and, st_sub: return st_write_arith;
			st_shift_load, st_shiftv_load: return st_shift_exec;
			st_shift_exec: return st_shift_write;
			st_xch1: return st_xch2;
			default: return st_final;
		endcase
	endfunction

	function automatic int cycles_for(instr_class_t cls);
		int base;
		case (cls)
			cls_add, cls_and, cls_sub, cls_xch: base = 7;
			cls_shift_imm, cls_shift_var: base = 8;
			cls_mfhi, cls_mflo, cls_slt: base = 6;
			default: base = 5;
		endcase
		return base + int'(fetch_wait_cycles) - 2;   // base counts a wait of 2
	endfunction

	task automatic check_cycle(input state_t exp_state);
		check_equal(32'(state), 32'(exp_state), "state");
		check_equal(32'(ctrl), 32'(expected_ctrl(exp_state, model_class, model_shift)),
			"ctrl");
		cycle_count++;
	endtask

	task automatic step(input state_t exp_state);
		@(negedge clock);
		check_cycle(exp_state);
	endtask

	task automatic run_instruction();
		int waited;
		state_t exp_state;
		waited = 0;
		cycle_count = 0;
		@(negedge clock);
		while (state == st_fetch) begin
			check_cycle(st_fetch);
			waited++;
			if (waited > int'(fetch_wait_cycles) + 8) begin
				abort_run("timeout: the state machine never left fetch");
			end
			@(negedge clock);
		end
		check_equal(32'(waited), 32'(fetch_wait_cycles), "cycles in fetch");
		check_cycle(st_fetch2);
		step(st_decode);
		model_class = classify(opcode, funct);   // values held on the edge leaving decode
		model_shift = shift_kind(funct);
		exp_state = st_decode;
		@(negedge clock);
		while (state != st_final) begin
			exp_state = successor(exp_state, model_class);
			check_cycle(exp_state);
			if (cycle_count > cycles_for(model_class) + 8) begin
				abort_run("timeout: the state machine never reached st_final");
			end
			@(negedge clock);
		end
		check_cycle(st_final);
		check_equal(32'(cycle_count), 32'(cycles_for(model_class)), "cycles per instruction");
	endtask

	initial begin
		reset = 1'b1;
		model_class = cls_unknown;   // matches the reset value of the latch
		model_shift = shift_load;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		step(st_reset);
		for (int n = 0; n < int'(instr_count); n++) begin
			run_instruction();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== verif/control_unit_checker.sv ====
`timescale 1ns/1ps

module control_unit_checker import cu_pkg::*; (
	input logic   clock,
	input logic   reset,
	input ctrl_t  ctrl,
	input state_t state
);

	ir_write_in_fetch: assert property (
		@(posedge clock) disable iff (reset)
		ctrl.ir_write |-> state == st_fetch
	) else $error("ir_write outside st_fetch");

	pc_write_in_fetch2: assert property (
		@(posedge clock) disable iff (reset)
		ctrl.pc_write |-> state == st_fetch2
	) else $error("pc_write outside st_fetch2");

	// every instruction ends by going back to fetch
	final_to_fetch: assert property (
		@(posedge clock) disable iff (reset)
		state == st_final |=> state == st_fetch
	) else $error("st_final not followed by st_fetch");

	no_pc_and_reg_write: assert property (
		@(posedge clock) disable iff (reset)
		!(ctrl.reg_write && ctrl.pc_write)
	) else $error("reg_write and pc_write active together");

endmodule

// ==== design/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import cu_pkg::*; #(
	parameter int unsigned fetch_wait_cycles = 2
) (
	input  logic    clock,
	input  logic    reset,
	input  opcode_t opcode,
	input  funct_t  funct,
	output ctrl_t   ctrl,
	output state_t  state
);

	decoded_t decoded;   // live decode of the ir fields
	decoded_t latched;   // decode held from st_decode onward

	instr_decoder u_decoder (
		.opcode  (opcode),
		.funct   (funct),
		.decoded (decoded)
	);

	state_sequencer #(
		.fetch_wait_cycles (fetch_wait_cycles)
	) u_sequencer (
		.clock   (clock),
		.reset   (reset),
		.decoded (decoded),
		.state   (state),
		.latched (latched)
	);

	// control word follows the registered state only
	control_encoder u_encoder (
		.state   (state),
		.latched (latched),
		.ctrl    (ctrl)
	);

endmodule

// ==== design/control_encoder.sv ====
`timescale 1ns/1ps

module control_encoder import cu_pkg::*; (
	input  state_t   state,
	input  decoded_t latched,
	output ctrl_t    ctrl
);

	logic shift_is_var;

	assign shift_is_var = (latched.instr_class == cls_shift_var);

	always_comb begin
		ctrl = '0;
		ctrl.pc_src     = pc_from_alu;
		ctrl.alu_src_a  = src_a_pc;
		ctrl.alu_src_b  = src_b_reg;
		ctrl.alu_op     = alu_none;
		ctrl.reg_dst    = dst_rt;
		ctrl.mem_to_reg = wb_alu_out;
		ctrl.shift_op   = shift_load;

		case (state)
			st_reset: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_sp;       // sp gets its start value
				ctrl.mem_to_reg = wb_sp_init;
			end
			st_fetch: begin
				ctrl.ir_write  = 1'b1;
				ctrl.alu_src_b = src_b_four;   // pc + 4
				ctrl.alu_op    = alu_add;
			end
			st_fetch2: begin
				ctrl.pc_write  = 1'b1;
				ctrl.alu_src_b = src_b_four;
				ctrl.alu_op    = alu_add;
			end
			st_decode: begin
				ctrl.alu_src_b     = src_b_offset;   // branch target precompute
				ctrl.alu_op        = alu_add;
				ctrl.alu_out_write = 1'b1;
				ctrl.a_write       = 1'b1;
				ctrl.b_write       = 1'b1;
				ctrl.xch_write     = 1'b1;
			end
			st_add: begin
				ctrl.alu_src_a     = src_a_reg;
				ctrl.alu_out_write = 1'b1;
				ctrl.alu_op        = alu_add;
			end
			st_and: begin
				ctrl.alu_src_a     = src_a_reg;
				ctrl.alu_out_write = 1'b1;
				ctrl.alu_op        = alu_and;
			end
			st_sub: begin
				ctrl.alu_src_a     = src_a_reg;
				ctrl.alu_out_write = 1'b1;
				ctrl.alu_op        = alu_sub;
			end
			st_write_arith: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rd;
				ctrl.mem_to_reg = wb_alu_out;
			end
			st_mfhi: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rd;
				ctrl.mem_to_reg = wb_hi;
			end
			st_mflo: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rd;
				ctrl.mem_to_reg = wb_lo;
			end
			st_slt: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rd;
				ctrl.mem_to_reg = wb_less;     // less flag, zero extended
				ctrl.alu_src_a  = src_a_reg;
				ctrl.alu_op     = alu_compare;
			end
			st_xch1: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rs;
				ctrl.mem_to_reg = wb_rt;
			end
			st_xch2: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rt;
				ctrl.mem_to_reg = wb_xch;      // old rs saved at decode
			end
			st_shift_load: begin
				ctrl.shift_op = shift_load;
			end
			st_shiftv_load: begin
				ctrl.shift_src = 1'b1;
				ctrl.shamt_src = 1'b1;
				ctrl.shift_op  = shift_load;
			end
			st_shift_exec: begin
				ctrl.shift_src = shift_is_var;
				ctrl.shamt_src = shift_is_var;
				ctrl.shift_op  = latched.shift_op;
			end
			st_shift_write: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rd;
				ctrl.mem_to_reg = wb_shift;
			end
			default: ;   // st_final keeps the defaults
		endcase
	end

endmodule

// ==== design/state_sequencer.sv ====
`timescale 1ns/1ps

module state_sequencer import cu_pkg::*; #(
	parameter int unsigned fetch_wait_cycles = 2
) (
	input  logic     clock,
	input  logic     reset,
	input  decoded_t decoded,
	output state_t   state,
	output decoded_t latched
);

	state_t      state_next;
	wait_count_t wait_count;
	logic        fetch_done;

	// last cycle of the fetch wait
	assign fetch_done = (wait_count == wait_count_t'(fetch_wait_cycles - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_reset;
			wait_count <= '0;
			latched    <= '{instr_class: cls_unknown, shift_op: shift_load};
		end else begin
			state <= state_next;
			if (state == st_fetch && !fetch_done) begin
				wait_count <= wait_count + 1'b1;
			end else begin
				wait_count <= '0;   // cleared once fetch is left
			end
			if (state == st_decode) begin
				latched <= decoded;   // ir may change after this edge
			end
		end
	end

	always_comb begin
		state_next = st_final;   // recovers from unused encodings
		case (state)
			st_reset:  state_next = st_fetch;
			st_fetch: begin
				if (fetch_done) begin
					state_next = st_fetch2;
				end else begin
					state_next = st_fetch;
				end
			end
			st_fetch2: state_next = st_decode;
			st_decode: begin
				case (decoded.instr_class)
					cls_add:       state_next = st_add;
					cls_and:       state_next = st_and;
					cls_sub:       state_next = st_sub;
					cls_shift_imm: state_next = st_shift_load;
					cls_shift_var: state_next = st_shiftv_load;
					cls_mfhi:      state_next = st_mfhi;
					cls_mflo:      state_next = st_mflo;
					cls_slt:       state_next = st_slt;
					cls_xch:       state_next = st_xch1;
					default:       state_next = st_final;   // unknown skips execute
				endcase
			end
			st_add,
			st_and,
			st_sub:         state_next = st_write_arith;
			st_shift_load,
			st_shiftv_load: state_next = st_shift_exec;
			st_shift_exec:  state_next = st_shift_write;
			st_xch1:        state_next = st_xch2;
			st_write_arith,
			st_shift_write,
			st_mfhi,
			st_mflo,
			st_slt,
			st_xch2:        state_next = st_final;
			st_final:       state_next = st_fetch;
			default:        state_next = st_final;
		endcase
	end

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import cu_pkg::*; (
	input  opcode_t  opcode,
	input  funct_t   funct,
	output decoded_t decoded
);

	instr_class_t instr_class;
	shift_op_t    shift_op;

	always_comb begin
		instr_class = cls_unknown;
		if (opcode == 6'h00) begin   // r-type only
			case (funct)
				6'h20: instr_class = cls_add;
				6'h24: instr_class = cls_and;
				6'h22: instr_class = cls_sub;
				6'h00,
				6'h02,
				6'h03: instr_class = cls_shift_imm;   // sll srl sra
				6'h04,
				6'h07: instr_class = cls_shift_var;   // sllv srav
				6'h10: instr_class = cls_mfhi;
				6'h12: instr_class = cls_mflo;
				6'h2a: instr_class = cls_slt;
				6'h05: instr_class = cls_xch;
				default: instr_class = cls_unknown;
			endcase
		end
	end

	// shift kind depends on funct alone
	always_comb begin
		case (funct)
			6'h00,
			6'h04: shift_op = shift_left;
			6'h02: shift_op = shift_right_logical;
			6'h03,
			6'h07: shift_op = shift_right_arith;
			default: shift_op = shift_load;
		endcase
	end

	assign decoded.instr_class = instr_class;
	assign decoded.shift_op    = shift_op;

endmodule

// ==== design/cu_pkg.sv ====
package cu_pkg;

	typedef logic [5:0] opcode_t;      // ir bits 31:26
	typedef logic [5:0] funct_t;       // r-type function field
	typedef logic [7:0] wait_count_t;  // cycles spent in fetch

	typedef enum logic [7:0] {
		st_reset       = 8'd0,
		st_fetch       = 8'd1,
		st_fetch2      = 8'd2,
		st_decode      = 8'd3,
		st_add         = 8'd4,
		st_and         = 8'd5,
		st_sub         = 8'd6,
		st_shift_load  = 8'd7,
		st_shiftv_load = 8'd10,
		st_mfhi        = 8'd12,
		st_mflo        = 8'd13,
		st_slt         = 8'd14,
		st_xch1        = 8'd20,
		st_xch2        = 8'd21,
		st_write_arith = 8'd133,
		st_shift_exec  = 8'd134,
		st_shift_write = 8'd135,
		st_final       = 8'd255
	} state_t;

	typedef enum logic [3:0] {
		cls_add,
		cls_and,
		cls_sub,
		cls_shift_imm,   // sll, srl, sra
		cls_shift_var,   // sllv, srav
		cls_mfhi,
		cls_mflo,
		cls_slt,
		cls_xch,
		cls_unknown
	} instr_class_t;

	typedef enum logic [2:0] {
		shift_load          = 3'd0,
		shift_left          = 3'd2,
		shift_right_logical = 3'd3,
		shift_right_arith   = 3'd4
	} shift_op_t;

	typedef enum logic [2:0] {
		alu_none    = 3'd0,
		alu_add     = 3'd1,
		alu_sub     = 3'd2,
		alu_and     = 3'd3,
		alu_compare = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		pc_from_alu = 3'd0,
		pc_from_epc = 3'd2
	} pc_src_t;

	typedef enum logic [1:0] {
		src_a_pc  = 2'd0,
		src_a_reg = 2'd2
	} alu_src_a_t;

	typedef enum logic [2:0] {
		src_b_reg    = 3'd0,
		src_b_four   = 3'd1,
		src_b_offset = 3'd4
	} alu_src_b_t;

	typedef enum logic [2:0] {
		dst_rt = 3'd0,
		dst_rs = 3'd1,
		dst_rd = 3'd2,
		dst_sp = 3'd3
	} reg_dst_t;

	typedef enum logic [3:0] {
		wb_alu_out = 4'd0,
		wb_hi      = 4'd2,
		wb_lo      = 4'd3,
		wb_shift   = 4'd6,
		wb_sp_init = 4'd7,   // stack pointer reset value
		wb_xch     = 4'd8,
		wb_less    = 4'd9,
		wb_rt      = 4'd10
	} mem_to_reg_t;

	typedef struct packed {
		instr_class_t instr_class;
		shift_op_t    shift_op;
	} decoded_t;

	typedef struct packed {
		logic        pc_write;
		logic        ir_write;
		logic        reg_write;
		logic        alu_out_write;
		logic        a_write;
		logic        b_write;
		logic        xch_write;
		logic        shift_src;    // 1 selects rs as shift operand
		logic        shamt_src;    // 1 selects rt as shift amount
		pc_src_t     pc_src;
		alu_src_a_t  alu_src_a;
		alu_src_b_t  alu_src_b;
		alu_op_t     alu_op;
		reg_dst_t    reg_dst;
		mem_to_reg_t mem_to_reg;
		shift_op_t   shift_op;
	} ctrl_t;

endpackage
